/* vlog.f */
+incdir+src
src/egress_pkg.sv
src/axis_async_fifo.sv
src/egress_credit_counter.sv
src/frame_egress_fsm.sv
src/axis_cdc_egress.sv
tests/tb_clock_gen.sv
tests/egress_asserts.sv
tests/tb_axis_cdc_egress.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CDC egress testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module tb_axis_cdc_egress \
    -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    exit 1
fi
exit 0

/* tests/tb_axis_cdc_egress.sv */
/*
 * CDC egress testbench
 * random frames from an xorshift source cross into output_clk, egress
 * beats are checked against a model array, a sink model returns credits
 */
`include "egress_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_axis_cdc_egress import egress_pkg::*;;

    // 60 frames of up to 8 beats, then 6 frames of 5 held beats
    localparam int max_beats      = 60 * 8 + 6 * 5;
    localparam int timeout_cycles = 40 * max_beats + 200;

    logic         output_clk;
    logic         input_clk;
    logic         async_rst;
    egress_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;
    egress_beat_t out_beat;
    logic         out_valid;
    logic         credit_return;
    logic         credit_error;

    // model of accepted ingress beats, written by stimulus, read by monitor
    egress_beat_t model_mem [0:1023];
    logic [9:0]   model_wr = '0;
    logic [9:0]   model_rd = '0;
    logic [31:0]  stim_state = 32'd21;
    int           cycle_count = 0;
    int           delivered_total = 0;
    int           returned_total = 0;
    int           extra_returns = 0;
    int           extra_sent = 0;
    logic         hold_returns = 1'b0;
    int           return_due [$];

    tb_clock_gen #(.period(4.0)) output_clk_gen (.clk(output_clk));
    tb_clock_gen #(.period(6.0)) input_clk_gen (.clk(input_clk));

    axis_cdc_egress axis_cdc_egress_i (
        .async_rst     (async_rst),
        .input_clk     (input_clk),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .output_clk    (output_clk),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .credit_return (credit_return),
        .credit_error  (credit_error)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_stim(output logic [31:0] r);
        stim_state = xorshift32(stim_state);
        r = stim_state;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_beat(input string name, input egress_beat_t exp, input egress_beat_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // one frame, called at posedge input_clk plus 1 ns
    task automatic send_frame(input int len);
        egress_beat_t beat;
        logic [31:0]  r;
        logic [31:0]  r2;
        logic         accepted;
        int           i;
        for (i = 0; i < len; i++) begin
            next_stim(r);
            next_stim(r2);
            beat.data = {r, r2};
            next_stim(r);
            beat.keep = r[`EGR_KEEP_WIDTH-1:0];
            beat.user = r[8];
            beat.last = (i == len - 1);
            // up to two idle input cycles before each beat
            repeat (int'(r[31:16] % 16'd3)) begin
                @(posedge input_clk);
                #1;
            end
            in_beat  = beat;
            in_valid = 1'b1;
            // ready is stable at the falling edge
            do begin
                @(negedge input_clk);
                accepted = in_ready;
                @(posedge input_clk);
                #1;
            end while (!accepted);
            model_mem[model_wr] = beat;
            model_wr = model_wr + 10'd1;
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        do begin
            @(negedge output_clk);
        end while (model_rd != model_wr || returned_total != delivered_total);
    endtask

    // run limit
    initial begin : watchdog
        forever begin
            @(posedge output_clk);
            cycle_count = cycle_count + 1;
            if (cycle_count >= timeout_cycles) begin
                report_failure($sformatf("timed out after %0d output_clk cycles", cycle_count));
            end
        end
    end

    // egress sink, data order, frame gap and credit limit
    initial begin : egress_monitor
        int gap_left;
        gap_left = 0;
        forever begin
            @(negedge output_clk);
            if (gap_left > 0) begin
                check_flag("frame_gap", 1'b0, out_valid);
                gap_left--;
            end else if (out_valid) begin
                if (model_rd == model_wr) begin
                    report_failure("egress beat delivered with no beat outstanding in the model");
                end
                check_beat("data_order", model_mem[model_rd], out_beat);
                model_rd = model_rd + 10'd1;
                delivered_total++;
                if (out_beat.last) begin
                    gap_left = `EGR_GAP_CYCLES;
                end
            end
            check_flag("credit_limit", 1'b1,
                       (delivered_total - returned_total) <= `EGR_CREDIT_INIT);
        end
    end

    // sink credit returns, one per delivered beat after 1 to 8 cycles
    initial begin : credit_returner
        logic [31:0] ret_state;
        int          scheduled;
        ret_state     = 32'd21;
        scheduled     = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge output_clk);
            #1;
            while (scheduled < delivered_total) begin
                ret_state = xorshift32(ret_state);
                return_due.push_back(cycle_count + 1 + int'(ret_state % 32'd8));
                scheduled++;
            end
            credit_return = 1'b0;
            if (!hold_returns && return_due.size() > 0 && return_due[0] <= cycle_count) begin
                void'(return_due.pop_front());
                credit_return = 1'b1;
                returned_total++;
            end else if (extra_sent < extra_returns) begin
                credit_return = 1'b1;
                extra_sent++;
                returned_total++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        int          f;
        async_rst = 1'b1;
        in_valid  = 1'b0;
        in_beat   = '0;
        // outputs quiet while in reset
        repeat (3) @(posedge output_clk);
        @(negedge output_clk);
        check_flag("reset_out_valid", 1'b0, out_valid);
        check_flag("reset_in_ready", 1'b0, in_ready);
        check_flag("reset_credit_error", 1'b0, credit_error);
        @(posedge output_clk);
        #1;
        async_rst = 1'b0;
        // synchronizers still hold ingress off
        @(negedge output_clk);
        check_flag("release_in_ready", 1'b0, in_ready);
        while (!in_ready) begin
            @(negedge input_clk);
        end
        @(posedge input_clk);
        #1;
        // random frames with free credit returns
        for (f = 0; f < 60; f++) begin
            next_stim(r);
            send_frame(1 + int'(r % 32'd8));
        end
        wait_drained();
        check_flag("no_credit_error", 1'b0, credit_error);
        // withhold credits until the FIFO backs up into ingress
        hold_returns = 1'b1;
        fork
            begin
                for (f = 0; f < 6; f++) begin
                    send_frame(5);
                end
            end
            begin
                do begin
                    @(negedge input_clk);
                end while (!(in_valid && !in_ready));
                repeat (30) @(negedge output_clk);
                check_flag("held_credits", 1'b1,
                           (delivered_total - returned_total) == `EGR_CREDIT_INIT);
                @(negedge input_clk);
                check_flag("held_in_ready", 1'b0, in_ready);
                hold_returns = 1'b0;
            end
        join
        wait_drained();
        // one return past the pool
        extra_returns = 1;
        while (extra_sent < 1) begin
            @(negedge output_clk);
        end
        repeat (2) @(negedge output_clk);
        check_flag("over_return_error", 1'b1, credit_error);
        repeat (10) @(negedge output_clk);
        check_flag("over_return_sticky", 1'b1, credit_error);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/egress_asserts.sv */
/*
 * egress FSM assertions
 * no beat during the frame gap, no pop without a credit,
 * egress port quiet for the gap cycles after a last beat
 */
`timescale 1ns/1ps
`default_nettype none

module egress_asserts import egress_pkg::*; (
    input  wire logic    output_clk,
    input  wire logic    async_rst,
    input  egress_state_t state,
    input  wire logic    fifo_valid,
    input  wire logic    credit_avail,
    input  egress_beat_t out_beat,
    input  wire logic    out_valid
);

    // gap state never drives the port
    gap_quiet: assert property (@(posedge output_clk) disable iff (async_rst)
        (state == EGR_GAP) |-> !out_valid)
        else $error("egress beat driven in the gap state");

    // each egress beat came from a valid FIFO entry popped under a credit
    pop_needs_credit: assert property (@(posedge output_clk) disable iff (async_rst)
        out_valid |-> $past(fifo_valid && credit_avail))
        else $error("egress beat without an available credit at its pop");

    // two idle cycles after a last beat
    gap_after_last_1: assert property (@(posedge output_clk) disable iff (async_rst)
        $past(out_valid && out_beat.last) |-> !out_valid)
        else $error("egress beat in first gap cycle");
    gap_after_last_2: assert property (@(posedge output_clk) disable iff (async_rst)
        $past(out_valid && out_beat.last, 2) |-> !out_valid)
        else $error("egress beat in second gap cycle");

endmodule

bind frame_egress_fsm egress_asserts egress_asserts_i (
    .output_clk   (output_clk),
    .async_rst    (async_rst),
    .state        (state),
    .fifo_valid   (fifo_valid),
    .credit_avail (credit_avail),
    .out_beat     (out_beat),
    .out_valid    (out_valid)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
/*
 * testbench clock source
 * free running clock, low at time zero
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2.0);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* src/axis_cdc_egress.sv */
/*
 * AXI4-Stream CDC egress
 * frames cross from input_clk to output_clk through an async FIFO and
 * leave on a credit-controlled egress port with an inter-frame gap
 */
`include "egress_config.svh"
`timescale 1ns/1ps
`default_nettype none

module axis_cdc_egress import egress_pkg::*; (
    input  wire logic    async_rst,

    // ingress, valid/ready
    input  wire logic    input_clk,
    input  egress_beat_t in_beat,
    input  wire logic    in_valid,
    output logic         in_ready,

    // egress, credit based
    input  wire logic    output_clk,
    output egress_beat_t out_beat,
    output logic         out_valid,
    input  wire logic    credit_return,
    output logic         credit_error
);

    // FIFO read port
    egress_beat_t fifo_beat;
    logic         fifo_valid;
    logic         fifo_ready;

    // credit handshake
    logic         credit_take;
    logic         credit_avail;

    // clock crossing
    axis_async_fifo #(
        .addr_width (`EGR_FIFO_ADDR_WIDTH)
    ) axis_async_fifo_i (
        .async_rst  (async_rst),
        .input_clk  (input_clk),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .output_clk (output_clk),
        .fifo_beat  (fifo_beat),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready)
    );

    // framing and gap
    frame_egress_fsm frame_egress_fsm_i (
        .output_clk   (output_clk),
        .async_rst    (async_rst),
        .fifo_beat    (fifo_beat),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .credit_avail (credit_avail),
        .credit_take  (credit_take),
        .out_beat     (out_beat),
        .out_valid    (out_valid)
    );

    // egress credit pool
    egress_credit_counter egress_credit_counter_i (
        .output_clk    (output_clk),
        .async_rst     (async_rst),
        .credit_take   (credit_take),
        .credit_return (credit_return),
        .credit_avail  (credit_avail),
        .credit_error  (credit_error)
    );

endmodule

`default_nettype wire

/* src/frame_egress_fsm.sv */
/*
 * frame egress FSM
 * pops beats from the CDC FIFO while credits are available, registers
 * them onto the egress port and holds an idle gap after each frame
 */
`include "egress_config.svh"
`timescale 1ns/1ps
`default_nettype none

module frame_egress_fsm import egress_pkg::*; (
    input  wire logic    output_clk,
    input  wire logic    async_rst,

    // FIFO read port
    input  egress_beat_t fifo_beat,
    input  wire logic    fifo_valid,
    output logic         fifo_ready,

    // credit counter
    input  wire logic    credit_avail,
    output logic         credit_take,

    // egress port
    output egress_beat_t out_beat,
    output logic         out_valid
);

    localparam int gap_width = $clog2(`EGR_GAP_CYCLES + 1);

    egress_state_t        state;
    logic [gap_width-1:0] gap_cnt;
    logic                 pop_allowed;
    logic                 pop;
    logic                 last_sent;

    // last beat of the frame sits on the egress port now
    assign last_sent = out_valid & out_beat.last;

    // no pop in gap, nor while the last beat goes out
    assign pop_allowed = (state == EGR_IDLE) || ((state == EGR_SEND) && !last_sent);

    assign fifo_ready  = pop_allowed & credit_avail;
    assign pop         = fifo_ready & fifo_valid;
    // one credit per beat popped
    assign credit_take = pop;

    // state and gap timing
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            state   <= EGR_IDLE;
            gap_cnt <= '0;
        end else begin
            case (state)
                EGR_IDLE: begin
                    gap_cnt <= '0;
                    if (pop) begin
                        state <= EGR_SEND;
                    end
                end
                EGR_SEND: begin
                    // frame done once last is registered
                    if (last_sent) begin
                        state <= EGR_GAP;
                    end
                end
                EGR_GAP: begin
                    if (gap_cnt == gap_width'(`EGR_GAP_CYCLES - 1)) begin
                        state   <= EGR_IDLE;
                        gap_cnt <= '0;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: begin
                    state   <= EGR_IDLE;
                    gap_cnt <= '0;
                end
            endcase
        end
    end

    // valid exactly one cycle after each pop
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

    // egress payload register
    always_ff @(posedge output_clk) begin
        if (pop) begin
            out_beat <= fifo_beat;
        end
    end

endmodule

`default_nettype wire

/* src/egress_credit_counter.sv */
/*
 * egress credit counter
 * starts full at the credit pool, one credit spent per sent beat and
 * one regained per sink return, sticky flag on a return past the pool
 */
`include "egress_config.svh"
`timescale 1ns/1ps
`default_nettype none

module egress_credit_counter (
    input  wire logic output_clk,
    input  wire logic async_rst,
    input  wire logic credit_take,
    input  wire logic credit_return,
    output logic      credit_avail,
    output logic      credit_error
);

    logic [`EGR_CREDIT_WIDTH-1:0] credit_cnt;

    // at least one credit left
    assign credit_avail = (credit_cnt != '0);

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            credit_cnt   <= `EGR_CREDIT_WIDTH'(`EGR_CREDIT_INIT);
            credit_error <= 1'b0;
        end else begin
            case ({credit_take, credit_return})
                // spend one, never wraps below zero
                2'b10: begin
                    if (credit_cnt != '0) begin
                        credit_cnt <= credit_cnt - 1'b1;
                    end
                end
                2'b01: begin
                    if (credit_cnt == `EGR_CREDIT_WIDTH'(`EGR_CREDIT_INIT)) begin
                        // sink returned more than it was given
                        credit_error <= 1'b1;
                    end else begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                // take and return together cancel
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/axis_async_fifo.sv */
/*
 * dual-clock AXI4-Stream FIFO
 * beats written under input_clk and read under output_clk, full and
 * empty from gray pointers passed through two-flop synchronizers,
 * three-stage reset synchronizer on each side, registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module axis_async_fifo import egress_pkg::*; #(
    parameter int addr_width = 4
) (
    input  wire logic         async_rst,

    // write side
    input  wire logic         input_clk,
    input  egress_beat_t      in_beat,
    input  wire logic         in_valid,
    output logic              in_ready,

    // read side
    input  wire logic         output_clk,
    output egress_beat_t      fifo_beat,
    output logic              fifo_valid,
    input  wire logic         fifo_ready
);

    // storage, no reset
    egress_beat_t mem [0:(1 << addr_width) - 1];

    // pointers carry one extra wrap bit
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_ptr_next;
    logic [addr_width:0] wr_ptr_gray;
    logic [addr_width:0] rd_ptr;
    logic [addr_width:0] rd_ptr_next;
    logic [addr_width:0] rd_ptr_gray;

    // gray pointers seen from the other domain
    logic [addr_width:0] wr_gray_sync1;
    logic [addr_width:0] wr_gray_sync2;
    logic [addr_width:0] rd_gray_sync1;
    logic [addr_width:0] rd_gray_sync2;

    // reset synchronizer chains, bit 2 is the local reset
    logic [2:0] in_rst_sync;
    logic [2:0] out_rst_sync;
    logic       in_rst;
    logic       out_rst;

    logic full;
    logic empty;
    logic write;
    logic read;

    assign in_rst  = in_rst_sync[2];
    assign out_rst = out_rst_sync[2];

    // full: top two gray bits differ, the rest match
    assign full = (wr_ptr_gray[addr_width:addr_width-1] ==
                   ~rd_gray_sync2[addr_width:addr_width-1]) &&
                  (wr_ptr_gray[addr_width-2:0] == rd_gray_sync2[addr_width-2:0]);
    // empty when gray pointers are equal
    assign empty = (rd_ptr_gray == wr_gray_sync2);

    assign in_ready = ~full & ~in_rst;
    assign write    = in_valid & in_ready;
    // refill output register when empty or being taken
    assign read     = (fifo_ready | ~fifo_valid) & ~empty;

    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    // input side held in reset until output side is also out
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_sync <= 3'b111;
        end else begin
            in_rst_sync <= {in_rst_sync[1], in_rst_sync[0] | out_rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_sync <= 3'b111;
        end else begin
            out_rst_sync <= {out_rst_sync[1:0], 1'b0};
        end
    end

    // write pointer, binary and gray
    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (write) begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    always_ff @(posedge input_clk) begin
        if (write) begin
            mem[wr_ptr[addr_width-1:0]] <= in_beat;
        end
    end

    // read pointer into write domain
    always_ff @(posedge input_clk or posedge in_rst) begin
        if (in_rst) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // read pointer and output valid
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
            fifo_valid  <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr      <= rd_ptr_next;
                rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
            end
            if (fifo_ready | ~fifo_valid) begin
                fifo_valid <= ~empty;
            end
        end
    end

    // registered read data
    always_ff @(posedge output_clk) begin
        if (read) begin
            fifo_beat <= mem[rd_ptr[addr_width-1:0]];
        end
    end

    // write pointer into read domain
    always_ff @(posedge output_clk or posedge out_rst) begin
        if (out_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

endmodule

`default_nettype wire

/* src/egress_pkg.sv */
/*
 * egress package
 * shared beat type carried from ingress through the FIFO to the
 * egress port, and the state encoding of the egress FSM
 */
`include "egress_config.svh"
`default_nettype none

package egress_pkg;

    // one AXI4-Stream beat, 74 bits with the default config
    typedef struct packed {
        logic [`EGR_DATA_WIDTH-1:0] data;
        // byte enables
        logic [`EGR_KEEP_WIDTH-1:0] keep;
        // sideband, passed through untouched
        logic                       user;
        // end of frame
        logic                       last;
    } egress_beat_t;

    // egress FSM states
    typedef enum logic [1:0] {
        EGR_IDLE = 2'd0,
        EGR_SEND = 2'd1,
        EGR_GAP  = 2'd2
    } egress_state_t;

endpackage

`default_nettype wire

/* src/egress_config.svh */
/*
 * egress subsystem configuration
 * sizes of the stream beat, the CDC FIFO, the egress credit
 * pool and the idle gap that follows each frame
 */
`ifndef EGRESS_CONFIG_SVH
`define EGRESS_CONFIG_SVH

// stream payload
`define EGR_DATA_WIDTH 64
`define EGR_KEEP_WIDTH (`EGR_DATA_WIDTH / 8)

// 16 entry FIFO
`define EGR_FIFO_ADDR_WIDTH 4

// egress credits, counter must hold the full pool
`define EGR_CREDIT_INIT 6
`define EGR_CREDIT_WIDTH 4

// idle output_clk cycles after a last beat
`define EGR_GAP_CYCLES 2

`endif
